/* hdl/fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

`default_nettype none

////////////////////////////////
// Datapath widths
////////////////////////////////

// Data and address word width
`define XLEN 32

// Instruction memory depth in words
`define IMEM_WORDS 64
// Word index width for the memory above
`define IMEM_AW 6

////////////////////////////////
// Serial line and loader
////////////////////////////////

// Bus clocks per UART bit period
`define CLKS_PER_BIT 8
// Header tag that starts a valid load
`define LOAD_TAG 8'hA5

// Program counter value after reset or load
`define RESET_PC 32'h0000_0000

`default_nettype wire

`endif

/* hdl/fetch_pkg.sv */
`include "fetch_consts.svh"

`default_nettype none

package fetch_pkg;

  // Redirect requests from later stages
  // Offset is a branch/jal offset or a jalr target
  typedef struct packed {
    logic             trap;
    logic             jalr;
    logic             jal;
    logic             branch;
    logic [`XLEN-1:0] off;
  } redirect_t;

  // Fetch to decode boundary
  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] ins;
    logic             valid;
  } if_id_t;

  // Register block write port
  typedef struct packed {
    logic             stb;
    logic [1:0]       addr;
    logic [`XLEN-1:0] data;
  } csr_wr_t;

  // Register map
  typedef enum logic [1:0] {
    CSR_CTRL   = 2'd0,
    CSR_MTVEC  = 2'd1,
    CSR_STATUS = 2'd2
  } csr_addr_e;

  // Instruction memory write port
  typedef struct packed {
    logic               stb;
    logic [`IMEM_AW-1:0] idx;
    logic [`XLEN-1:0]   data;
  } imem_wr_t;

  // Load header, tag sits in the first received byte
  typedef struct packed {
    logic [15:0] count;
    logic [7:0]  start;
    logic [7:0]  tag;
  } load_hdr_t;

  // One assembled word, header view or raw instruction view
  typedef union packed {
    load_hdr_t        hdr;
    logic [`XLEN-1:0] raw;
  } load_word_u;

endpackage

`default_nettype wire

/* hdl/uart_rx.sv */
`include "fetch_consts.svh"

`default_nettype none

module uart_rx
(
  input  logic       bus,
  input  logic       rst,
  input  logic       rx,
  output logic [7:0] rx_byte,
  output logic       rx_stb
);

  // Bit timer sized from the bit period
  localparam int CW = $clog2(`CLKS_PER_BIT);
  localparam logic [CW-1:0] HALF_BIT = CW'(`CLKS_PER_BIT / 2 - 1);
  localparam logic [CW-1:0] FULL_BIT = CW'(`CLKS_PER_BIT - 1);

  // FSM states
  localparam logic [1:0] RX_IDLE  = 2'd0;
  localparam logic [1:0] RX_START = 2'd1;
  localparam logic [1:0] RX_DATA  = 2'd2;
  localparam logic [1:0] RX_STOP  = 2'd3;

  logic [1:0]    state;
  logic [CW-1:0] cnt;
  logic [2:0]    bit_cnt;
  logic [7:0]    shreg;
  logic          rx_meta;
  logic          rx_sync;
  logic          rx_prev;
  logic          fall;
  logic          bit_tick;

  // Start bit edge on the synchronized line
  assign fall     = rx_prev & ~rx_sync;
  assign bit_tick = (cnt == FULL_BIT);
  assign rx_byte  = shreg;

  always_ff @(posedge bus)
  begin
    if (rst)
    begin
      state   <= RX_IDLE;
      cnt     <= '0;
      bit_cnt <= '0;
      rx_stb  <= 1'b0;
      // Line idles high
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
      rx_stb  <= 1'b0;
      cnt     <= cnt + 1'b1;
      case (state)
        RX_IDLE:
        begin
          cnt <= '0;
          if (fall)
            state <= RX_START;
        end
        RX_START:
        begin
          // Recheck mid start bit, a glitch returns to idle
          if (cnt == HALF_BIT)
          begin
            cnt   <= '0;
            state <= rx_sync ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA:
        begin
          // Now aligned to mid bit
          if (bit_tick)
          begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7)
              state <= RX_STOP;
          end
        end
        default:
        begin
          // Framing error drops the byte
          if (bit_tick)
          begin
            rx_stb <= rx_sync;
            state  <= RX_IDLE;
          end
        end
      endcase
    end
  end

  // LSB first shift at each data bit center
  always_ff @(posedge bus)
  begin
    if (state == RX_DATA && bit_tick)
      shreg <= {rx_sync, shreg[7:1]};
  end

endmodule

`default_nettype wire

/* hdl/prog_loader.sv */
`include "fetch_consts.svh"

`default_nettype none

module prog_loader
(
  input  logic                  bus,
  input  logic                  rst,
  input  logic [7:0]            rx_byte,
  input  logic                  rx_stb,
  output fetch_pkg::imem_wr_t   imem_wr,
  output logic                  loading,
  output logic                  load_done
);

  fetch_pkg::load_word_u word_q;
  fetch_pkg::load_word_u word_nx;
  logic [1:0]            byte_cnt;
  logic                  word_stb;
  logic [`IMEM_AW-1:0]   idx;
  logic [15:0]           remain;
  logic                  wr_stb;
  logic [`IMEM_AW-1:0]   wr_idx;
  logic [`XLEN-1:0]      wr_data;

  // Little endian, newest byte enters at the top
  assign word_nx.raw = {rx_byte, word_q.raw[`XLEN-1:8]};
  assign word_stb    = rx_stb && (byte_cnt == 2'd3);

  assign imem_wr.stb  = wr_stb;
  assign imem_wr.idx  = wr_idx;
  assign imem_wr.data = wr_data;

  always_ff @(posedge bus)
  begin
    if (rx_stb)
      word_q <= word_nx;
  end

  ////////////////////////////////
  // Header and data FSM
  ////////////////////////////////

  always_ff @(posedge bus)
  begin
    if (rst)
    begin
      byte_cnt  <= '0;
      loading   <= 1'b0;
      load_done <= 1'b0;
      wr_stb    <= 1'b0;
    end
    else
    begin
      load_done <= 1'b0;
      wr_stb    <= 1'b0;
      if (rx_stb)
        byte_cnt <= byte_cnt + 1'b1;
      if (word_stb && !loading)
      begin
        // Wrong tag leaves us waiting for the next header
        if (word_nx.hdr.tag == `LOAD_TAG)
        begin
          loading   <= (word_nx.hdr.count != 16'd0);
          load_done <= (word_nx.hdr.count == 16'd0);
          idx       <= word_nx.hdr.start[`IMEM_AW-1:0];
          remain    <= word_nx.hdr.count;
        end
      end
      else if (word_stb)
      begin
        wr_stb  <= 1'b1;
        wr_idx  <= idx;
        wr_data <= word_nx.raw;
        idx     <= idx + 1'b1;
        remain  <= remain - 1'b1;
        // Last word ends the load with the done pulse
        if (remain == 16'd1)
        begin
          loading   <= 1'b0;
          load_done <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/imem.sv */
`include "fetch_consts.svh"

`default_nettype none

module imem
(
  input  logic                 bus,
  input  fetch_pkg::imem_wr_t  wr,
  input  logic                 rd_en,
  input  logic [`IMEM_AW-1:0]  rd_idx,
  output logic [`XLEN-1:0]     rd_data
);

  // Word array, contents come only from the loader
  logic [`XLEN-1:0] mem [`IMEM_WORDS];

  // Single write port
  always_ff @(posedge bus)
  begin
    if (wr.stb)
      mem[wr.idx] <= wr.data;
  end

  // Registered read, holds while rd_en is low
  // Same index read and write returns old data
  always_ff @(posedge bus)
  begin
    if (rd_en)
      rd_data <= mem[rd_idx];
  end

endmodule

`default_nettype wire

/* hdl/fetch_csr.sv */
`include "fetch_consts.svh"

`default_nettype none

module fetch_csr
(
  input  logic                bus,
  input  logic                rst,
  input  fetch_pkg::csr_wr_t  wr,
  input  logic                load_done,
  output logic                run,
  output logic                halt,
  output logic [`XLEN-1:0]    mtvec,
  output logic [`XLEN-1:0]    status
);

  logic       loaded;
  logic [7:0] load_cnt;

  // Status layout
  // Bit 0 loaded flag, bits 15:8 completed loads
  assign status = {16'd0, load_cnt, 7'd0, loaded};

  always_ff @(posedge bus)
  begin
    if (rst)
    begin
      run      <= 1'b0;
      halt     <= 1'b0;
      mtvec    <= '0;
      loaded   <= 1'b0;
      load_cnt <= '0;
    end
    else
    begin
      if (wr.stb)
      begin
        case (fetch_pkg::csr_addr_e'(wr.addr))
          fetch_pkg::CSR_CTRL:
          begin
            run  <= wr.data[0];
            halt <= wr.data[1];
          end
          // Vector stays word aligned
          fetch_pkg::CSR_MTVEC:  mtvec  <= {wr.data[`XLEN-1:2], 2'b00};
          fetch_pkg::CSR_STATUS: loaded <= 1'b0;
          default:               ;
        endcase
      end
      // A finishing load wins over a clearing write
      if (load_done)
      begin
        loaded   <= 1'b1;
        load_cnt <= load_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/fetch_stage.sv */
`include "fetch_consts.svh"

`default_nettype none

module fetch_stage
(
  input  logic                 bus,
  input  logic                 rst,
  input  fetch_pkg::redirect_t redir,
  input  logic                 run,
  input  logic                 halt,
  input  logic                 mem_hold,
  input  logic                 loading,
  input  logic [`XLEN-1:0]     mtvec,
  output logic                 rd_en,
  output logic [`IMEM_AW-1:0]  rd_idx,
  input  logic [`XLEN-1:0]     rd_data,
  output fetch_pkg::if_id_t    if_id
);

  logic             en;
  logic [`XLEN-1:0] pc_q;
  logic [`XLEN-1:0] next_pc;
  logic [`XLEN-1:0] bnd_pc;
  logic             bnd_valid;

  ////////////////////////////////
  // Enable and next address
  ////////////////////////////////

  // Any stall source freezes the pc
  assign en = run & ~halt & ~mem_hold & ~loading;

  // Trap first, then jalr, then pc relative, then sequential
  // Relative jumps are based on the boundary pc
  always_comb
  begin
    if (redir.trap)
      next_pc = mtvec;
    else if (redir.jalr)
      next_pc = redir.off;
    else if (redir.jal || redir.branch)
      next_pc = bnd_pc + redir.off;
    else
      next_pc = pc_q + `XLEN'd4;
  end

  // Current pc is read in the same cycle it advances
  assign rd_en  = en;
  assign rd_idx = pc_q[`IMEM_AW+1:2];

  always_ff @(posedge bus)
  begin
    // Loading pins fetch at the reset address
    if (rst || loading)
      pc_q <= `RESET_PC;
    else if (en)
      pc_q <= next_pc;
  end

  ////////////////////////////////
  // Decode boundary
  ////////////////////////////////

  always_ff @(posedge bus)
  begin
    if (rst)
      bnd_valid <= 1'b0;
    else
      bnd_valid <= en;
  end

  // Pc of the word now leaving memory
  always_ff @(posedge bus)
  begin
    if (en)
      bnd_pc <= pc_q;
  end

  assign if_id.pc    = bnd_pc;
  assign if_id.valid = bnd_valid;
  // Instruction forced to zero during reset
  assign if_id.ins   = rst ? '0 : rd_data;

endmodule

`default_nettype wire

/* hdl/fetch_top.sv */
`include "fetch_consts.svh"

`default_nettype none

module fetch_top
(
  input  logic                 bus,
  input  logic                 rst,
  input  logic                 rx,
  input  fetch_pkg::csr_wr_t   csr_wr,
  input  fetch_pkg::redirect_t redir,
  input  logic                 mem_hold,
  output fetch_pkg::if_id_t    if_id,
  output logic [`XLEN-1:0]     status
);

  logic [7:0]          rx_byte;
  logic                rx_stb;
  fetch_pkg::imem_wr_t imem_wr;
  logic                loading;
  logic                load_done;
  logic                run;
  logic                halt;
  logic [`XLEN-1:0]    mtvec;
  logic                rd_en;
  logic [`IMEM_AW-1:0] rd_idx;
  logic [`XLEN-1:0]    rd_data;

  // Serial load path
  uart_rx u_rx (.bus, .rst, .rx, .rx_byte, .rx_stb);

  prog_loader u_loader (.bus, .rst, .rx_byte, .rx_stb, .imem_wr, .loading, .load_done);

  // Memory shared by loader writes and fetch reads
  imem u_imem (.bus, .wr(imem_wr), .rd_en, .rd_idx, .rd_data);

  // Run control and trap vector
  fetch_csr u_csr (.bus, .rst, .wr(csr_wr), .load_done, .run, .halt, .mtvec, .status);

  fetch_stage u_fetch
  (
    .bus,
    .rst,
    .redir,
    .run,
    .halt,
    .mem_hold,
    .loading,
    .mtvec,
    .rd_en,
    .rd_idx,
    .rd_data,
    .if_id
  );

endmodule

`default_nettype wire

/* tests/fetch_assertions.sv */
`include "fetch_consts.svh"

`default_nettype none

module fetch_assertions
(
  input logic              bus,
  input logic              rst,
  input logic              run,
  input logic              halt,
  input logic              mem_hold,
  input logic              loading,
  input fetch_pkg::if_id_t if_id,
  input logic [`XLEN-1:0]  pc_q
);

  // Loading blocks fetch, boundary empties next cycle
  property load_blocks_fetch;
    @(posedge bus) disable iff (rst)
      loading |=> !if_id.valid;
  endproperty

  // A stalled cycle issues nothing
  property stall_no_valid;
    @(posedge bus) disable iff (rst)
      (!run || halt || mem_hold) |=> !if_id.valid;
  endproperty

  // Word aligned fetch address
  property pc_aligned;
    @(posedge bus) disable iff (rst)
      pc_q[1:0] == 2'b00;
  endproperty

  assert property (load_blocks_fetch)
    else $error("boundary valid in the cycle after loading");
  assert property (stall_no_valid)
    else $error("boundary valid in the cycle after a disabled cycle");
  assert property (pc_aligned)
    else $error("pc low bits not zero");

endmodule

// Checks ride along inside every fetch stage
bind fetch_stage fetch_assertions u_fetch_chk
(
  .bus      (bus),
  .rst      (rst),
  .run      (run),
  .halt     (halt),
  .mem_hold (mem_hold),
  .loading  (loading),
  .if_id    (if_id),
  .pc_q     (pc_q)
);

`default_nettype wire

/* tests/fetch_tb.sv */
`include "fetch_consts.svh"

`default_nettype none

module fetch_tb;

  // Run length budget
  localparam int FRAME_CYCLES   = 10 * `CLKS_PER_BIT;
  // Header and data bytes of all three serial phases
  localparam int BYTES_SENT     = 60;
  localparam int FETCH_CYCLES   = 100;
  localparam int TIMEOUT_CYCLES = 3 * (BYTES_SENT * FRAME_CYCLES + FETCH_CYCLES);

  logic                 bus = 1'b0;
  logic                 rst;
  logic                 rx;
  fetch_pkg::csr_wr_t   csr_wr;
  fetch_pkg::redirect_t redir;
  logic                 mem_hold;
  fetch_pkg::if_id_t    if_id;
  logic [`XLEN-1:0]     status;

  // Model state
  logic [`XLEN-1:0] m_mem [`IMEM_WORDS];
  logic [`XLEN-1:0] m_pc;
  logic [`XLEN-1:0] m_bnd;
  logic [`XLEN-1:0] m_mtvec;
  logic             m_run;
  logic             m_halt;
  logic             m_loading = 1'b0;
  logic             exp_valid;
  logic [`XLEN-1:0] exp_pc;
  logic [`XLEN-1:0] exp_ins;
  logic             checking = 1'b0;
  logic [`XLEN-1:0] rng;
  int               fetch_errs = 0;
  int               tb_errs = 0;
  int               cycles = 0;

  fetch_top uut (.bus, .rst, .rx, .csr_wr, .redir, .mem_hold, .if_id, .status);

  always #50 bus = ~bus;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Next address: trap, jalr, relative to boundary pc, then plus four
  function automatic logic [`XLEN-1:0] ref_next_pc(input fetch_pkg::redirect_t r,
      input logic [`XLEN-1:0] pc, input logic [`XLEN-1:0] bnd, input logic [`XLEN-1:0] tvec);
    if (r.trap)
      return tvec;
    if (r.jalr)
      return r.off;
    if (r.jal || r.branch)
      return bnd + r.off;
    return pc + 32'd4;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got,
      input logic [31:0] exp, inout int errs);
    if (got !== exp)
    begin
      errs++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  // Advance to the drive point just after the next rising edge
  task automatic step();
    @(posedge bus);
    #10;
  endtask

  task automatic send_bit(input logic b);
    rx = b;
    repeat (`CLKS_PER_BIT) step();
  endtask

  // 8N1, LSB first
  task automatic send_byte(input logic [7:0] data);
    logic [7:0] sh;
    sh = data;
    send_bit(1'b0);
    repeat (8)
    begin
      send_bit(sh[0]);
      sh = sh >> 1;
    end
    send_bit(1'b1);
  endtask

  task automatic send_word(input logic [31:0] w);
    logic [31:0] sh;
    sh = w;
    repeat (4)
    begin
      send_byte(sh[7:0]);
      sh = sh >> 8;
    end
  endtask

  task automatic csr_write(input fetch_pkg::csr_addr_e addr, input logic [`XLEN-1:0] data);
    csr_wr.stb  = 1'b1;
    csr_wr.addr = addr;
    csr_wr.data = data;
    step();
    csr_wr.stb  = 1'b0;
  endtask

  task automatic fill_random(input logic [`IMEM_AW-1:0] first, input int n);
    logic [`IMEM_AW-1:0] idx;
    idx = first;
    repeat (n)
    begin
      rng = xorshift32(rng);
      m_mem[idx] = rng;
      idx = idx + 1'b1;
    end
  endtask

  // Header then model words, then wait for the load count to reach loads
  task automatic load_program(input logic [7:0] start, input logic [15:0] count,
      input logic [7:0] loads);
    logic [`IMEM_AW-1:0] idx;
    int                  waited;
    idx = start[`IMEM_AW-1:0];
    waited = 0;
    m_loading = 1'b1;
    send_word({count, start, `LOAD_TAG});
    repeat (count)
    begin
      send_word(m_mem[idx]);
      idx = idx + 1'b1;
    end
    // Done pulse trails the last stop bit
    while (status[15:8] != loads && waited < FRAME_CYCLES)
    begin
      step();
      waited++;
    end
    if (status[15:8] != loads)
    begin
      tb_errs++;
      $display("Load number %0d never completed, status is %h", loads, status);
    end
    m_loading = 1'b0;
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  always @(posedge bus)
  begin
    if (rst)
    begin
      m_pc      = `RESET_PC;
      m_bnd     = '0;
      m_mtvec   = '0;
      m_run     = 1'b0;
      m_halt    = 1'b0;
      exp_valid = 1'b0;
    end
    else
    begin
      exp_valid = m_run && !m_halt && !mem_hold && !m_loading;
      if (exp_valid)
      begin
        exp_pc  = m_pc;
        exp_ins = m_mem[m_pc[`IMEM_AW+1:2]];
        m_pc    = ref_next_pc(redir, m_pc, m_bnd, m_mtvec);
        m_bnd   = exp_pc;
      end
      // Loader pins pc at reset value
      if (m_loading)
        m_pc = `RESET_PC;
      // Register writes count from the next cycle
      if (csr_wr.stb)
      begin
        case (csr_wr.addr)
          fetch_pkg::CSR_CTRL:
          begin
            m_run  = csr_wr.data[0];
            m_halt = csr_wr.data[1];
          end
          fetch_pkg::CSR_MTVEC: m_mtvec = {csr_wr.data[`XLEN-1:2], 2'b00};
          default: ;
        endcase
      end
    end
  end

  // Boundary is stable at the falling edge
  always @(negedge bus)
  begin
    if (checking)
    begin
      if (if_id.valid && !exp_valid)
      begin
        fetch_errs++;
        $display("Valid instruction at pc %h while no fetch was expected", if_id.pc);
      end
      else
      begin
        check_val("if_id.valid", 32'(if_id.valid), 32'(exp_valid), fetch_errs);
        if (exp_valid)
        begin
          check_val("if_id.pc", if_id.pc, exp_pc, fetch_errs);
          check_val("if_id.ins", if_id.ins, exp_ins, fetch_errs);
        end
      end
    end
  end

  always @(posedge bus)
  begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES)
    begin
      $display("Timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial
  begin
    rst      = 1'b1;
    rx       = 1'b1;
    csr_wr   = '0;
    redir    = '0;
    mem_hold = 1'b0;
    rng      = 32'd5;
    step();
    step();
    rst      = 1'b0;
    checking = 1'b1;

    // First program, eight words at index 0
    fill_random('0, 8);
    load_program(8'd0, 16'd8, 8'd1);
    check_val("status", status, 32'h0000_0101, tb_errs);
    csr_write(fetch_pkg::CSR_CTRL, 32'h1);
    repeat (3) step();

    // Jalr first, so the boundary pc no longer trails the pc by four
    redir.jalr = 1'b1;
    redir.off  = 32'd4;
    step();
    // Branch then jal, both relative to the boundary pc
    redir        = '0;
    redir.branch = 1'b1;
    redir.off    = 32'd8;
    step();
    redir     = '0;
    redir.jal = 1'b1;
    redir.off = 32'd8;
    step();
    redir = '0;
    step();

    // Trap outranks jalr in the same cycle
    csr_write(fetch_pkg::CSR_MTVEC, 32'd16);
    redir.trap = 1'b1;
    redir.jalr = 1'b1;
    redir.off  = 32'd4;
    step();
    redir = '0;
    step();

    // Stalls from mem_hold and halt
    mem_hold = 1'b1;
    repeat (3) step();
    mem_hold = 1'b0;
    csr_write(fetch_pkg::CSR_CTRL, 32'h3);
    repeat (3) step();
    csr_write(fetch_pkg::CSR_CTRL, 32'h1);
    csr_write(fetch_pkg::CSR_CTRL, 32'h0);

    // Bad tag, data words must be ignored
    send_word({16'd2, 8'd0, 8'h3C});
    send_word(32'h1111_1100);
    send_word(32'h2222_2200);
    repeat (FRAME_CYCLES) step();
    check_val("status", status, 32'h0000_0101, tb_errs);

    // Second program patches words 4 and 5
    fill_random(6'd4, 2);
    load_program(8'd4, 16'd2, 8'd2);
    check_val("status", status, 32'h0000_0201, tb_errs);
    csr_write(fetch_pkg::CSR_CTRL, 32'h1);
    repeat (7) step();
    csr_write(fetch_pkg::CSR_CTRL, 32'h0);
    repeat (2) step();

    $display("Errors: %0d fetch, %0d control", fetch_errs, tb_errs);
    if (fetch_errs + tb_errs == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+hdl
hdl/fetch_pkg.sv
hdl/uart_rx.sv
hdl/prog_loader.sv
hdl/imem.sv
hdl/fetch_csr.sv
hdl/fetch_stage.sv
hdl/fetch_top.sv
tests/fetch_assertions.sv
tests/fetch_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module fetch_tb -o fetch_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Build failed, see build.log"
  exit 1
fi

./obj_dir/fetch_sim > sim.log 2>&1
rc=$?
cat sim.log
if [ $rc -ne 0 ]; then
  echo "Simulator exited with status $rc"
  exit 1
fi

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
exit 0
